//--- lsu_fwd_pkg.sv
// ********************
// store-to-load forwarding shared widths, size codes and double-word view
// ********************
package lsu_fwd_pkg;

   // ********************
   // widths
   // ********************
   localparam int ADDR_W         = 32;                      // byte address
   localparam int WORD_W         = 32;                      // data word
   localparam int BYTES_PER_WORD = 4;
   localparam int BYTE_W         = 8;
   localparam int OFF_W          = $clog2(BYTES_PER_WORD);  // byte offset in a word
   localparam int WIDX_W         = ADDR_W - OFF_W;          // word index, addr[31:2]

   // ********************
   // access size codes
   // ********************
   // code 3 is not a legal size
   localparam int SIZE_W = 2;

   localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
   localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
   localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

   // ********************
   // double-word view
   // ********************
   // an access shifted by its byte offset spans two words, lo then hi
   // comparators pick single bytes, the merge works on the two words
   typedef union packed {
      struct packed {
         logic [WORD_W-1:0] hi;                              // word at end address
         logic [WORD_W-1:0] lo;                              // word at start address
      } w;
      logic [2*BYTES_PER_WORD-1:0][BYTE_W-1:0] b;           // byte 0 is lo word byte 0
   } dword_u;

endpackage

//--- lsu_stage_pipe.sv
// ********************
// dc1 to dc5 operation registers with end address, byte enable and
// store data expansion into double-word position
// ********************
`timescale 1ns/1ps

module lsu_stage_pipe
   import lsu_fwd_pkg::*;
#(
   parameter int NUM_FWD_STAGES = 3
) (
   input  logic                      clk,
   input  logic                      rst_n,

   input  logic                      op_valid_dc1,
   input  logic                      op_load_dc1,
   input  logic                      op_store_dc1,
   input  logic [SIZE_W-1:0]         op_size_dc1,
   input  logic [ADDR_W-1:0]         op_addr_dc1,
   input  logic                      op_sideeffect_dc1,
   input  logic [WORD_W-1:0]         store_data_dc1,

   output logic                      ld_valid_dc2,        // valid load in dc2
   output logic                      ld_sideeffect_dc2,
   output logic [WIDX_W-1:0]         ld_addr_lo_dc2,      // start word index
   output logic [WIDX_W-1:0]         ld_addr_hi_dc2,      // end word index
   output logic [BYTES_PER_WORD-1:0] ld_byteen_lo_dc2,
   output logic [BYTES_PER_WORD-1:0] ld_byteen_hi_dc2,
   output logic [OFF_W-1:0]          ld_offset_dc2,

   // index 0 is dc3
   output logic                      st_valid     [NUM_FWD_STAGES],
   output logic [WIDX_W-1:0]         st_addr_lo   [NUM_FWD_STAGES],
   output logic [WIDX_W-1:0]         st_addr_hi   [NUM_FWD_STAGES],
   output logic [BYTES_PER_WORD-1:0] st_byteen_lo [NUM_FWD_STAGES],
   output logic [BYTES_PER_WORD-1:0] st_byteen_hi [NUM_FWD_STAGES],
   output dword_u                    st_data      [NUM_FWD_STAGES]
);

   localparam int DEPTH = NUM_FWD_STAGES + 1;                // dc2 plus the store stages

   logic [BYTES_PER_WORD-1:0]   byteen_dc1;
   logic [OFF_W-1:0]            len_m1_dc1;                  // access bytes minus one
   logic [ADDR_W-1:0]           end_addr_dc1;
   logic [2*BYTES_PER_WORD-1:0] byteen_ext_dc1;
   dword_u                      data_ext_dc1;

   // stage registers, index 0 holds dc2
   logic                        ld_valid_q;
   logic                        sideeffect_q;
   logic [OFF_W-1:0]            offset_q;
   logic                        st_valid_q  [DEPTH];
   logic [WIDX_W-1:0]           addr_lo_q   [DEPTH];
   logic [WIDX_W-1:0]           addr_hi_q   [DEPTH];
   logic [BYTES_PER_WORD-1:0]   byteen_lo_q [DEPTH];
   logic [BYTES_PER_WORD-1:0]   byteen_hi_q [DEPTH];
   dword_u                      data_q      [DEPTH];

   // ********************
   // dc1 decode
   // ********************
   always_comb begin
      case (op_size_dc1)
         SIZE_BYTE: begin
            byteen_dc1 = 4'b0001;
            len_m1_dc1 = 2'd0;
         end
         SIZE_HALF: begin
            byteen_dc1 = 4'b0011;
            len_m1_dc1 = 2'd1;
         end
         SIZE_WORD: begin
            byteen_dc1 = 4'b1111;
            len_m1_dc1 = 2'd3;
         end
         default: begin
            byteen_dc1 = '0;                                 // no bytes touched
            len_m1_dc1 = 2'd0;
         end
      endcase
   end

   assign end_addr_dc1 = op_addr_dc1 + ADDR_W'(len_m1_dc1);

   // move enables and data up by the byte offset, upper half spills into hi word
   assign byteen_ext_dc1 = {{BYTES_PER_WORD{1'b0}}, byteen_dc1} << op_addr_dc1[OFF_W-1:0];
   assign data_ext_dc1   = {{WORD_W{1'b0}}, store_data_dc1} << {op_addr_dc1[OFF_W-1:0], 3'b000};

   // ********************
   // stage registers
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ld_valid_q <= 1'b0;
         for (int k = 0; k < DEPTH; k++) begin
            st_valid_q[k] <= 1'b0;
         end
      end else begin
         ld_valid_q    <= op_valid_dc1 & op_load_dc1;
         st_valid_q[0] <= op_valid_dc1 & op_store_dc1;
         for (int k = 1; k < DEPTH; k++) begin
            st_valid_q[k] <= st_valid_q[k-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      sideeffect_q   <= op_sideeffect_dc1;
      offset_q       <= op_addr_dc1[OFF_W-1:0];
      addr_lo_q[0]   <= op_addr_dc1[ADDR_W-1:OFF_W];
      addr_hi_q[0]   <= end_addr_dc1[ADDR_W-1:OFF_W];
      byteen_lo_q[0] <= byteen_ext_dc1[BYTES_PER_WORD-1:0];
      byteen_hi_q[0] <= byteen_ext_dc1[2*BYTES_PER_WORD-1:BYTES_PER_WORD];
      data_q[0]      <= data_ext_dc1;
      for (int k = 1; k < DEPTH; k++) begin
         addr_lo_q[k]   <= addr_lo_q[k-1];
         addr_hi_q[k]   <= addr_hi_q[k-1];
         byteen_lo_q[k] <= byteen_lo_q[k-1];
         byteen_hi_q[k] <= byteen_hi_q[k-1];
         data_q[k]      <= data_q[k-1];
      end
   end

   // ********************
   // outputs
   // ********************
   assign ld_valid_dc2      = ld_valid_q;
   assign ld_sideeffect_dc2 = sideeffect_q;
   assign ld_addr_lo_dc2    = addr_lo_q[0];
   assign ld_addr_hi_dc2    = addr_hi_q[0];
   assign ld_byteen_lo_dc2  = byteen_lo_q[0];
   assign ld_byteen_hi_dc2  = byteen_hi_q[0];
   assign ld_offset_dc2     = offset_q;

   for (genvar k = 0; k < NUM_FWD_STAGES; k++) begin : st_out_gen
      assign st_valid[k]     = st_valid_q[k+1];
      assign st_addr_lo[k]   = addr_lo_q[k+1];
      assign st_addr_hi[k]   = addr_hi_q[k+1];
      assign st_byteen_lo[k] = byteen_lo_q[k+1];
      assign st_byteen_hi[k] = byteen_hi_q[k+1];
      assign st_data[k]      = data_q[k+1];
   end

   // a valid operation is one kind only and has a legal size
   op_legal_a: assert property (@(posedge clk) disable iff (!rst_n)
      op_valid_dc1 |-> !(op_load_dc1 && op_store_dc1) && (op_size_dc1 != 2'd3))
      else $error("illegal operation at dc1");

endmodule

//--- lsu_fwd_stage_cmp.sv
// ********************
// byte hit and data pick of one older store against the dc2 load
// ********************
`timescale 1ns/1ps

module lsu_fwd_stage_cmp
   import lsu_fwd_pkg::*;
(
   input  logic [WIDX_W-1:0]         ld_addr_lo_dc2,
   input  logic [WIDX_W-1:0]         ld_addr_hi_dc2,
   input  logic [BYTES_PER_WORD-1:0] ld_byteen_lo_dc2,
   input  logic [BYTES_PER_WORD-1:0] ld_byteen_hi_dc2,

   input  logic                      st_valid,            // valid store in this stage
   input  logic [WIDX_W-1:0]         st_addr_lo,
   input  logic [WIDX_W-1:0]         st_addr_hi,
   input  logic [BYTES_PER_WORD-1:0] st_byteen_lo,
   input  logic [BYTES_PER_WORD-1:0] st_byteen_hi,
   input  dword_u                    st_data,

   output logic [BYTES_PER_WORD-1:0] byte_hit_lo,         // per load lo byte
   output logic [BYTES_PER_WORD-1:0] byte_hit_hi,         // per load hi byte
   output logic [WORD_W-1:0]         fwd_lo,
   output logic [WORD_W-1:0]         fwd_hi
);

   // word matches, named load half then store half
   logic                      match_lo_lo;
   logic                      match_lo_hi;
   logic                      match_hi_lo;
   logic                      match_hi_hi;
   logic [BYTES_PER_WORD-1:0] hit_lo_lo;
   logic [BYTES_PER_WORD-1:0] hit_lo_hi;
   logic [BYTES_PER_WORD-1:0] hit_hi_lo;
   logic [BYTES_PER_WORD-1:0] hit_hi_hi;

   assign match_lo_lo = st_valid & (ld_addr_lo_dc2 == st_addr_lo);
   assign match_lo_hi = st_valid & (ld_addr_lo_dc2 == st_addr_hi);
   assign match_hi_lo = st_valid & (ld_addr_hi_dc2 == st_addr_lo);
   assign match_hi_hi = st_valid & (ld_addr_hi_dc2 == st_addr_hi);

   // a store with hi enables spans two different words, so at most one
   // of its halves can feed a given load byte
   always_comb begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         hit_lo_lo[i] = match_lo_lo & ld_byteen_lo_dc2[i] & st_byteen_lo[i];
         hit_lo_hi[i] = match_lo_hi & ld_byteen_lo_dc2[i] & st_byteen_hi[i];
         hit_hi_lo[i] = match_hi_lo & ld_byteen_hi_dc2[i] & st_byteen_lo[i];
         hit_hi_hi[i] = match_hi_hi & ld_byteen_hi_dc2[i] & st_byteen_hi[i];

         byte_hit_lo[i] = hit_lo_lo[i] | hit_lo_hi[i];
         byte_hit_hi[i] = hit_hi_lo[i] | hit_hi_hi[i];

         fwd_lo[BYTE_W*i +: BYTE_W] =
            ({BYTE_W{hit_lo_lo[i]}} & st_data.b[i]) |
            ({BYTE_W{hit_lo_hi[i]}} & st_data.b[BYTES_PER_WORD+i]);
         fwd_hi[BYTE_W*i +: BYTE_W] =
            ({BYTE_W{hit_hi_lo[i]}} & st_data.b[i]) |
            ({BYTE_W{hit_hi_hi[i]}} & st_data.b[BYTES_PER_WORD+i]);
      end

      // no load byte takes both halves of one store
      assert final (((hit_lo_lo & hit_lo_hi) == '0) && ((hit_hi_lo & hit_hi_hi) == '0))
         else $error("load byte matched both halves of one store");
   end

endmodule

//--- lsu_fwd_merge.sv
// ********************
// priority merge of store hits, full hit check, alignment and dc3 select
// ********************
`timescale 1ns/1ps

module lsu_fwd_merge
   import lsu_fwd_pkg::*;
#(
   parameter int NUM_FWD_STAGES = 3
) (
   input  logic                      clk,
   input  logic                      rst_n,

   input  logic                      ld_valid_dc2,
   input  logic                      ld_sideeffect_dc2,
   input  logic [BYTES_PER_WORD-1:0] ld_byteen_lo_dc2,
   input  logic [BYTES_PER_WORD-1:0] ld_byteen_hi_dc2,
   input  logic [OFF_W-1:0]          ld_offset_dc2,

   // index 0 is the youngest store stage (dc3)
   input  logic [BYTES_PER_WORD-1:0] byte_hit_lo [NUM_FWD_STAGES],
   input  logic [BYTES_PER_WORD-1:0] byte_hit_hi [NUM_FWD_STAGES],
   input  logic [WORD_W-1:0]         fwd_lo      [NUM_FWD_STAGES],
   input  logic [WORD_W-1:0]         fwd_hi      [NUM_FWD_STAGES],

   input  logic [WORD_W-1:0]         ld_bus_data_dc3,     // bus return word
   output logic [WORD_W-1:0]         bus_read_data_dc3,
   output logic                      ld_full_hit_dc3,
   output logic                      ld_valid_dc3
);

   logic [BYTES_PER_WORD-1:0] any_hit_lo;
   logic [BYTES_PER_WORD-1:0] any_hit_hi;
   dword_u                    fwd_dw_dc2;                    // merged hi:lo forward data
   dword_u                    aligned_dw_dc2;
   logic                      full_hit_lo_dc2;
   logic                      full_hit_hi_dc2;
   logic                      full_hit_dc2;
   logic [WORD_W-1:0]         fwd_data_dc3;

   // ********************
   // youngest-first byte merge
   // ********************
   always_comb begin
      any_hit_lo = '0;
      any_hit_hi = '0;
      fwd_dw_dc2 = '0;
      // oldest first, so a younger stage overwrites the byte
      for (int k = NUM_FWD_STAGES - 1; k >= 0; k--) begin
         for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (byte_hit_lo[k][i]) begin
               fwd_dw_dc2.b[i] = fwd_lo[k][BYTE_W*i +: BYTE_W];
               any_hit_lo[i]   = 1'b1;
            end
            if (byte_hit_hi[k][i]) begin
               fwd_dw_dc2.b[BYTES_PER_WORD+i] = fwd_hi[k][BYTE_W*i +: BYTE_W];
               any_hit_hi[i]                  = 1'b1;
            end
         end
      end
   end

   // every enabled byte needs a source
   assign full_hit_lo_dc2 = &(any_hit_lo | ~ld_byteen_lo_dc2);
   assign full_hit_hi_dc2 = &(any_hit_hi | ~ld_byteen_hi_dc2);
   assign full_hit_dc2    = full_hit_lo_dc2 & full_hit_hi_dc2 & ld_valid_dc2 &
                            ~ld_sideeffect_dc2;             // side-effect loads go to the bus

   // bring the first load byte down to bit 0
   assign aligned_dw_dc2 = fwd_dw_dc2 >> {ld_offset_dc2, 3'b000};

   // ********************
   // dc3 register
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ld_valid_dc3    <= 1'b0;
         ld_full_hit_dc3 <= 1'b0;
      end else begin
         ld_valid_dc3    <= ld_valid_dc2;
         ld_full_hit_dc3 <= full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3 <= aligned_dw_dc2.w.lo;
   end

   assign bus_read_data_dc3 = ld_full_hit_dc3 ? fwd_data_dc3 : ld_bus_data_dc3;

   // the alignment shift needs the first load byte in the lo word at the offset
   first_byte_a: assert property (@(posedge clk) disable iff (!rst_n)
      ld_valid_dc2 |-> ld_byteen_lo_dc2[ld_offset_dc2])
      else $error("valid load in dc2 without its first byte enabled");

endmodule

//--- lsu_fwd_top.sv
// ********************
// store-to-load forwarding unit, pipe plus comparators plus merge
// ********************
`timescale 1ns/1ps

module lsu_fwd_top
   import lsu_fwd_pkg::*;
#(
   parameter int NUM_FWD_STAGES = 3
) (
   input  logic              clk,
   input  logic              rst_n,

   input  logic              op_valid_dc1,
   input  logic              op_load_dc1,
   input  logic              op_store_dc1,
   input  logic [SIZE_W-1:0] op_size_dc1,
   input  logic [ADDR_W-1:0] op_addr_dc1,
   input  logic              op_sideeffect_dc1,
   input  logic [WORD_W-1:0] store_data_dc1,

   input  logic [WORD_W-1:0] ld_bus_data_dc3,
   output logic [WORD_W-1:0] bus_read_data_dc3,
   output logic              ld_full_hit_dc3,
   output logic              ld_valid_dc3
);

   // dc2 load view
   logic                      ld_valid_dc2;
   logic                      ld_sideeffect_dc2;
   logic [WIDX_W-1:0]         ld_addr_lo_dc2;
   logic [WIDX_W-1:0]         ld_addr_hi_dc2;
   logic [BYTES_PER_WORD-1:0] ld_byteen_lo_dc2;
   logic [BYTES_PER_WORD-1:0] ld_byteen_hi_dc2;
   logic [OFF_W-1:0]          ld_offset_dc2;

   // older store stages
   logic                      st_valid     [NUM_FWD_STAGES];
   logic [WIDX_W-1:0]         st_addr_lo   [NUM_FWD_STAGES];
   logic [WIDX_W-1:0]         st_addr_hi   [NUM_FWD_STAGES];
   logic [BYTES_PER_WORD-1:0] st_byteen_lo [NUM_FWD_STAGES];
   logic [BYTES_PER_WORD-1:0] st_byteen_hi [NUM_FWD_STAGES];
   dword_u                    st_data      [NUM_FWD_STAGES];

   // comparator results
   logic [BYTES_PER_WORD-1:0] byte_hit_lo  [NUM_FWD_STAGES];
   logic [BYTES_PER_WORD-1:0] byte_hit_hi  [NUM_FWD_STAGES];
   logic [WORD_W-1:0]         fwd_lo       [NUM_FWD_STAGES];
   logic [WORD_W-1:0]         fwd_hi       [NUM_FWD_STAGES];

   lsu_stage_pipe #(
      .NUM_FWD_STAGES (NUM_FWD_STAGES)
   ) pipe_inst (
      .clk               (clk),
      .rst_n             (rst_n),
      .op_valid_dc1      (op_valid_dc1),
      .op_load_dc1       (op_load_dc1),
      .op_store_dc1      (op_store_dc1),
      .op_size_dc1       (op_size_dc1),
      .op_addr_dc1       (op_addr_dc1),
      .op_sideeffect_dc1 (op_sideeffect_dc1),
      .store_data_dc1    (store_data_dc1),
      .ld_valid_dc2      (ld_valid_dc2),
      .ld_sideeffect_dc2 (ld_sideeffect_dc2),
      .ld_addr_lo_dc2    (ld_addr_lo_dc2),
      .ld_addr_hi_dc2    (ld_addr_hi_dc2),
      .ld_byteen_lo_dc2  (ld_byteen_lo_dc2),
      .ld_byteen_hi_dc2  (ld_byteen_hi_dc2),
      .ld_offset_dc2     (ld_offset_dc2),
      .st_valid          (st_valid),
      .st_addr_lo        (st_addr_lo),
      .st_addr_hi        (st_addr_hi),
      .st_byteen_lo      (st_byteen_lo),
      .st_byteen_hi      (st_byteen_hi),
      .st_data           (st_data)
   );

   // one comparator per older store stage
   for (genvar k = 0; k < NUM_FWD_STAGES; k++) begin : cmp_gen
      lsu_fwd_stage_cmp cmp_inst (
         .ld_addr_lo_dc2   (ld_addr_lo_dc2),
         .ld_addr_hi_dc2   (ld_addr_hi_dc2),
         .ld_byteen_lo_dc2 (ld_byteen_lo_dc2),
         .ld_byteen_hi_dc2 (ld_byteen_hi_dc2),
         .st_valid         (st_valid[k]),
         .st_addr_lo       (st_addr_lo[k]),
         .st_addr_hi       (st_addr_hi[k]),
         .st_byteen_lo     (st_byteen_lo[k]),
         .st_byteen_hi     (st_byteen_hi[k]),
         .st_data          (st_data[k]),
         .byte_hit_lo      (byte_hit_lo[k]),
         .byte_hit_hi      (byte_hit_hi[k]),
         .fwd_lo           (fwd_lo[k]),
         .fwd_hi           (fwd_hi[k])
      );
   end

   lsu_fwd_merge #(
      .NUM_FWD_STAGES (NUM_FWD_STAGES)
   ) merge_inst (
      .clk               (clk),
      .rst_n             (rst_n),
      .ld_valid_dc2      (ld_valid_dc2),
      .ld_sideeffect_dc2 (ld_sideeffect_dc2),
      .ld_byteen_lo_dc2  (ld_byteen_lo_dc2),
      .ld_byteen_hi_dc2  (ld_byteen_hi_dc2),
      .ld_offset_dc2     (ld_offset_dc2),
      .byte_hit_lo       (byte_hit_lo),
      .byte_hit_hi       (byte_hit_hi),
      .fwd_lo            (fwd_lo),
      .fwd_hi            (fwd_hi),
      .ld_bus_data_dc3   (ld_bus_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3),
      .ld_valid_dc3      (ld_valid_dc3)
   );

endmodule

//--- tb_lsu_fwd_ref.svh
// ********************
// reference model of forwarding and the history of issued operations
// ********************
`ifndef TB_LSU_FWD_REF_SVH
`define TB_LSU_FWD_REF_SVH

localparam int HIST_LEN = 1024;

// one entry per issue cycle, bubbles included
logic              hist_valid [HIST_LEN];
logic              hist_load  [HIST_LEN];
logic              hist_store [HIST_LEN];
logic [SIZE_W-1:0] hist_size  [HIST_LEN];
logic [ADDR_W-1:0] hist_addr  [HIST_LEN];
logic              hist_se    [HIST_LEN];
logic [WORD_W-1:0] hist_data  [HIST_LEN];

function automatic int size_bytes(input logic [SIZE_W-1:0] size);
   return (size == SIZE_WORD) ? 4 : ((size == SIZE_HALF) ? 2 : 1);
endfunction

// each load byte comes from the youngest of the three older stores covering it
function automatic void expect_load(input int idx, output logic exp_hit,
                                    output logic [WORD_W-1:0] exp_data);
   logic [ADDR_W-1:0] baddr;
   logic              found;
   int                s;
   int                boff;
   exp_hit  = hist_valid[idx] & hist_load[idx] & ~hist_se[idx];
   exp_data = '0;                                            // bytes above the load stay zero
   for (int j = 0; j < size_bytes(hist_size[idx]); j++) begin
      baddr = hist_addr[idx] + ADDR_W'(j);
      found = 1'b0;
      for (int k = 1; k <= NUM_FWD_STAGES; k++) begin
         s = idx - k;                                        // k = 1 is dc3
         if (!found && s >= 0 && hist_valid[s] && hist_store[s] && baddr >= hist_addr[s] &&
             baddr < hist_addr[s] + ADDR_W'(size_bytes(hist_size[s]))) begin
            boff               = int'(baddr - hist_addr[s]);
            exp_data[8*j +: 8] = hist_data[s][8*boff +: 8];
            found              = 1'b1;
         end
      end
      exp_hit = exp_hit & found;
   end
endfunction

`endif

//--- tb_lsu_fwd.sv
// ********************
// testbench of the forwarding unit, directed cases then random traffic
// ********************
`timescale 1ns/1ps

module tb_lsu_fwd
   import lsu_fwd_pkg::*;
();

   localparam int NUM_FWD_STAGES = 3;
   localparam int DIRECTED_OPS   = 40;
   localparam int RANDOM_OPS     = 400;
   localparam int NUM_OPS        = DIRECTED_OPS + RANDOM_OPS;
   localparam int WATCHDOG_NS    = (NUM_OPS + 20) * 8;
   localparam logic [ADDR_W-1:0] DIR_BASE  = 32'h0000_1000;
   localparam logic [ADDR_W-1:0] RAND_BASE = 32'h0000_2000;   // 16 byte random window

   logic              clk = 1'b0;
   logic              rst_n;
   logic              op_valid_dc1;
   logic              op_load_dc1;
   logic              op_store_dc1;
   logic [SIZE_W-1:0] op_size_dc1;
   logic [ADDR_W-1:0] op_addr_dc1;
   logic              op_sideeffect_dc1;
   logic [WORD_W-1:0] store_data_dc1;
   logic [WORD_W-1:0] ld_bus_data_dc3;
   logic [WORD_W-1:0] bus_read_data_dc3;
   logic              ld_full_hit_dc3;
   logic              ld_valid_dc3;
   int                edge_cnt;                               // rising edges so far
   int                n_issued;

   `include "tb_lsu_fwd_ref.svh"

   logic [WORD_W-1:0] bus_hist [HIST_LEN];                    // bus word per cycle

   lsu_fwd_top #(
      .NUM_FWD_STAGES (NUM_FWD_STAGES)
   ) lsu_fwd_top_inst (
      .clk               (clk),
      .rst_n             (rst_n),
      .op_valid_dc1      (op_valid_dc1),
      .op_load_dc1       (op_load_dc1),
      .op_store_dc1      (op_store_dc1),
      .op_size_dc1       (op_size_dc1),
      .op_addr_dc1       (op_addr_dc1),
      .op_sideeffect_dc1 (op_sideeffect_dc1),
      .store_data_dc1    (store_data_dc1),
      .ld_bus_data_dc3   (ld_bus_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3),
      .ld_valid_dc3      (ld_valid_dc3)
   );

   always #4 clk = ~clk;

   always @(posedge clk) edge_cnt <= edge_cnt + 1;

   task automatic abort_run;
      $display("TEST FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic compare_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_word(input string what, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] exp);
      if (got !== exp) begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // one operation per cycle, 1 ns after the edge, with a fresh bus word
   task automatic issue_op(input logic load, input logic store, input logic [SIZE_W-1:0] size,
                           input logic [ADDR_W-1:0] addr, input logic se,
                           input logic [WORD_W-1:0] data);
      @(posedge clk);
      #1;
      op_valid_dc1         = load | store;
      op_load_dc1          = load;
      op_store_dc1         = store;
      op_size_dc1          = size;
      op_addr_dc1          = addr;
      op_sideeffect_dc1    = se;
      store_data_dc1       = data;
      ld_bus_data_dc3      = $urandom;
      hist_valid[edge_cnt] = load | store;
      hist_load[edge_cnt]  = load;
      hist_store[edge_cnt] = store;
      hist_size[edge_cnt]  = size;
      hist_addr[edge_cnt]  = addr;
      hist_se[edge_cnt]    = se;
      hist_data[edge_cnt]  = data;
      bus_hist[edge_cnt]   = ld_bus_data_dc3;
      n_issued++;
   endtask

   task automatic issue_idle(input int n);
      for (int i = 0; i < n; i++) begin
         issue_op(1'b0, 1'b0, SIZE_BYTE, '0, 1'b0, '0);
      end
   endtask

   // ********************
   // compare process
   // ********************
   always @(negedge clk) begin
      int                idx;
      logic              exp_valid;
      logic              exp_hit;
      logic [WORD_W-1:0] exp_data;
      idx       = edge_cnt - 2;                               // dc3 holds the op of two edges ago
      exp_valid = 1'b0;
      exp_hit   = 1'b0;
      exp_data  = '0;
      if (idx >= 0) begin
         exp_valid = hist_valid[idx] & hist_load[idx];
         expect_load(idx, exp_hit, exp_data);
      end
      compare_bit("ld_valid_dc3", ld_valid_dc3, exp_valid);
      compare_bit("ld_full_hit_dc3", ld_full_hit_dc3, exp_hit);
      if (exp_valid) begin
         if (!exp_hit) exp_data = bus_hist[edge_cnt];
         compare_word("bus_read_data_dc3", bus_read_data_dc3, exp_data);
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the test did not finish within %0d ns", WATCHDOG_NS);
      abort_run();
   end

   // ********************
   // stimulus
   // ********************
   initial begin
      int kind;
      void'($urandom(32'hb598_ba8b));
      n_issued = 0;
      for (int i = 0; i < HIST_LEN; i++) begin
         hist_valid[i] = 1'b0;
         hist_load[i]  = 1'b0;
         hist_store[i] = 1'b0;
         hist_size[i]  = SIZE_BYTE;
      end
      rst_n             = 1'b0;
      op_valid_dc1      = 1'b0;
      op_load_dc1       = 1'b0;
      op_store_dc1      = 1'b0;
      op_size_dc1       = SIZE_BYTE;
      op_addr_dc1       = '0;
      op_sideeffect_dc1 = 1'b0;
      store_data_dc1    = '0;
      ld_bus_data_dc3   = '0;
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;

      issue_op(1'b0, 1'b1, SIZE_WORD, DIR_BASE, 1'b0, 32'hcafe_f00d);  // store then word load
      issue_idle(1);
      issue_op(1'b1, 1'b0, SIZE_WORD, DIR_BASE, 1'b0, '0);
      issue_idle(3);
      issue_op(1'b1, 1'b0, SIZE_WORD, DIR_BASE + 32'h40, 1'b0, '0);   // nothing to forward
      issue_idle(3);
      // dc5 word store under a younger dc3 halfword store
      issue_op(1'b0, 1'b1, SIZE_WORD, DIR_BASE + 32'h10, 1'b0, 32'h1122_3344);
      issue_idle(1);
      issue_op(1'b0, 1'b1, SIZE_HALF, DIR_BASE + 32'h11, 1'b0, 32'h0000_aabb);
      issue_op(1'b1, 1'b0, SIZE_WORD, DIR_BASE + 32'h10, 1'b0, '0);
      issue_idle(3);
      // halfword across a word boundary, hi part missing then covered
      issue_op(1'b0, 1'b1, SIZE_WORD, DIR_BASE + 32'h04, 1'b0, 32'h5566_7788);
      issue_op(1'b1, 1'b0, SIZE_HALF, DIR_BASE + 32'h07, 1'b0, '0);
      issue_op(1'b0, 1'b1, SIZE_BYTE, DIR_BASE + 32'h08, 1'b0, 32'h0000_0099);
      issue_op(1'b1, 1'b0, SIZE_HALF, DIR_BASE + 32'h07, 1'b0, '0);
      issue_idle(3);
      issue_op(1'b0, 1'b1, SIZE_WORD, DIR_BASE + 32'h16, 1'b0, 32'hdead_beef);  // two sources
      issue_op(1'b0, 1'b1, SIZE_BYTE, DIR_BASE + 32'h1a, 1'b0, 32'h0000_00c3);
      issue_op(1'b1, 1'b0, SIZE_WORD, DIR_BASE + 32'h17, 1'b0, '0);
      issue_idle(3);
      issue_op(1'b0, 1'b1, SIZE_WORD, DIR_BASE + 32'h30, 1'b0, 32'h0bad_f00d);  // side effect
      issue_op(1'b1, 1'b0, SIZE_WORD, DIR_BASE + 32'h30, 1'b1, '0);
      issue_idle(DIRECTED_OPS - n_issued);

      for (int i = 0; i < RANDOM_OPS; i++) begin
         kind = $urandom % 8;
         if (kind < 3) begin
            issue_op(1'b0, 1'b1, SIZE_W'($urandom % 3), RAND_BASE + ($urandom % 16), 1'b0,
                     $urandom);
         end else if (kind < 7) begin
            issue_op(1'b1, 1'b0, SIZE_W'($urandom % 3), RAND_BASE + ($urandom % 16),
                     ($urandom % 6) == 0, '0);
         end else begin
            issue_idle(1);
         end
      end
      issue_idle(4);                                          // drain the pipe
      @(negedge clk);
      #1;
      $display("TEST OK");
      $finish;
   end

endmodule

//--- tb.f
+incdir+.
lsu_fwd_pkg.sv
lsu_stage_pipe.sv
lsu_fwd_stage_cmp.sv
lsu_fwd_merge.sv
lsu_fwd_top.sv
tb_lsu_fwd.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the forwarding unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f tb.f --top-module tb_lsu_fwd -o tb_lsu_fwd_sim; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_lsu_fwd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
   echo "simulation failed"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "simulation passed"
exit 0
